// ==== hdl/fc_fmt_pkg.sv ====
/*
 * fully connected layer number format
 * Q6.10 sample type, accumulator widths, saturation limits and the
 * weight rule shared by the weight ROM and the reference model
 */
`default_nettype none

package fc_fmt_pkg;

  typedef logic signed [15:0] sample_t;  // Q6.10
  typedef logic signed [31:0] prod_t;    // Q12.20, full product
  typedef logic signed [39:0] acc_t;     // unscaled running sum of products

  localparam int FRAC_BITS = 10;

  localparam sample_t SAMPLE_MAX = 16'sh7FFF;
  localparam sample_t SAMPLE_MIN = 16'sh8000;

  // weights are multiples of 1/16 in [-0.5, +0.5]
  function automatic sample_t weight_of(input int out_idx, input int in_idx);
    int step_val;
    step_val = ((out_idx * 7 + in_idx * 3) % 17) - 8;  // -8 .. +8
    return sample_t'(step_val <<< 6);
  endfunction

endpackage

`default_nettype wire

// ==== hdl/fc_ctrl_pkg.sv ====
/*
 * fully connected layer geometry and control
 * vector sizes, lane count, index types, controller states and the
 * structs that carry compute steps and lane results
 */
`default_nettype none

package fc_ctrl_pkg;

  localparam int N_INPUTS  = 100;
  localparam int N_OUTPUTS = 10;
  localparam int N_LANES   = 2;
  localparam int N_PASSES  = N_OUTPUTS / N_LANES;

  typedef logic [6:0] in_idx_t;
  typedef logic [2:0] pass_t;
  typedef logic [3:0] out_idx_t;

  localparam in_idx_t LAST_INDEX = in_idx_t'(N_INPUTS - 1);
  localparam pass_t   LAST_PASS  = pass_t'(N_PASSES - 1);

  // one sample per lane, lane 0 in the low bits
  typedef fc_fmt_pkg::sample_t [N_LANES-1:0] lane_data_t;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FLUSH
  } fsm_state_t;

  typedef struct packed {
    logic    valid;
    logic    first;  // index 0 of a pass
    logic    last;   // index 99 of a pass
    pass_t   pass;
    in_idx_t index;
  } fc_step_t;

  typedef struct packed {
    logic       valid;
    pass_t      pass;
    lane_data_t data;
  } fc_lane_result_t;

endpackage

`default_nettype wire

// ==== hdl/fc_vector_buffer.sv ====
/*
 * two-bank input vector store
 * one bank fills from the input strobe while the other is reread once
 * per pass; a bank is handed back by the controller after its results
 */
`timescale 1ns/1ps
`default_nettype none

module fc_vector_buffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  fc_fmt_pkg::sample_t  in_sample,
  input  fc_ctrl_pkg::in_idx_t rd_index,
  output fc_fmt_pkg::sample_t  rd_sample,
  output logic                 vector_ready,
  input  logic                 bank_release
);

  fc_fmt_pkg::sample_t  mem [2][fc_ctrl_pkg::N_INPUTS];
  fc_ctrl_pkg::in_idx_t wr_ptr;
  logic                 wr_bank;
  logic                 rd_bank;
  logic [1:0]           full;    // one flag per bank
  logic                 wr_wrap;

  assign wr_wrap      = in_valid && (wr_ptr == fc_ctrl_pkg::LAST_INDEX);  // 100th sample
  assign vector_ready = full[rd_bank];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      wr_bank <= 1'b0;
      rd_bank <= 1'b0;
      full    <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_wrap ? '0 : wr_ptr + 1'b1;
      end
      if (wr_wrap) begin
        full[wr_bank] <= 1'b1;
        wr_bank       <= ~wr_bank;
      end
      if (bank_release) begin
        full[rd_bank] <= 1'b0;  // never the bank being written
        rd_bank       <= ~rd_bank;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_bank][wr_ptr] <= in_sample;
    end
    rd_sample <= mem[rd_bank][rd_index];  // one cycle read latency
  end

  // no back-pressure, so a third vector has nowhere to go
  a_no_write_when_full : assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> !(full[0] && full[1]))
    else $error("input sample while both banks are full");

  a_release_full_bank : assert property (@(posedge clk) disable iff (!rst_n)
    bank_release |-> vector_ready)
    else $error("bank release on an empty read bank");

endmodule

`default_nettype wire

// ==== hdl/fc_weight_rom.sv ====
/*
 * weight table
 * one weight per lane for every pass and input index, built from the
 * weight rule at elaboration, read with one cycle of latency
 */
`timescale 1ns/1ps
`default_nettype none

module fc_weight_rom (
  input  logic                    clk,
  input  fc_ctrl_pkg::pass_t      pass,
  input  fc_ctrl_pkg::in_idx_t    index,
  output fc_ctrl_pkg::lane_data_t weights
);

  fc_ctrl_pkg::lane_data_t weight_table [fc_ctrl_pkg::N_PASSES][fc_ctrl_pkg::N_INPUTS];

  // lane l of pass p works on output row p*N_LANES+l
  function automatic fc_ctrl_pkg::lane_data_t lane_row(input int p, input int i);
    fc_ctrl_pkg::lane_data_t row;
    for (int l = 0; l < fc_ctrl_pkg::N_LANES; l++) begin
      row[l] = fc_fmt_pkg::weight_of(p * fc_ctrl_pkg::N_LANES + l, i);
    end
    return row;
  endfunction

  for (genvar p = 0; p < fc_ctrl_pkg::N_PASSES; p++) begin : g_pass
    for (genvar i = 0; i < fc_ctrl_pkg::N_INPUTS; i++) begin : g_index
      assign weight_table[p][i] = lane_row(p, i);
    end
  end

  always_ff @(posedge clk) begin
    weights <= weight_table[pass][index];
  end

endmodule

`default_nettype wire

// ==== hdl/fc_mac_lane.sv ====
/*
 * multiply-accumulate lane
 * sums one weight row against the buffered inputs over a pass, then
 * scales back to Q6.10 and saturates the result
 */
`timescale 1ns/1ps
`default_nettype none

module fc_mac_lane (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fc_ctrl_pkg::fc_step_t step,
  input  fc_fmt_pkg::sample_t   sample,
  input  fc_fmt_pkg::sample_t   weight,
  output fc_fmt_pkg::sample_t   result,
  output logic                  result_valid
);

  fc_fmt_pkg::prod_t   product;
  fc_fmt_pkg::acc_t    acc;
  fc_fmt_pkg::acc_t    sum_next;
  fc_fmt_pkg::acc_t    scaled;
  fc_fmt_pkg::sample_t sat_value;

  assign product  = sample * weight;  // Q12.20
  assign sum_next = step.first ? fc_fmt_pkg::acc_t'(product)
                               : acc + fc_fmt_pkg::acc_t'(product);
  assign scaled   = sum_next >>> fc_fmt_pkg::FRAC_BITS;  // floor back to Q6.10

  always_comb begin
    if (scaled > fc_fmt_pkg::acc_t'(fc_fmt_pkg::SAMPLE_MAX)) begin
      sat_value = fc_fmt_pkg::SAMPLE_MAX;
    end else if (scaled < fc_fmt_pkg::acc_t'(fc_fmt_pkg::SAMPLE_MIN)) begin
      sat_value = fc_fmt_pkg::SAMPLE_MIN;
    end else begin
      sat_value = fc_fmt_pkg::sample_t'(scaled);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= step.valid && step.last;
    end
  end

  always_ff @(posedge clk) begin
    if (step.valid) begin
      acc <= sum_next;
    end
    if (step.valid && step.last) begin
      result <= sat_value;  // includes the final product
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fc_step_counter.sv ====
/*
 * compute step counter
 * walks input index 0..99 for each of the five passes while enabled,
 * with no gap between passes
 */
`timescale 1ns/1ps
`default_nettype none

module fc_step_counter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run_en,
  output fc_ctrl_pkg::fc_step_t step,
  output logic                  done_steps
);

  fc_ctrl_pkg::in_idx_t index_q;
  fc_ctrl_pkg::pass_t   pass_q;
  logic                 at_last;
  logic                 at_final;

  assign at_last  = (index_q == fc_ctrl_pkg::LAST_INDEX);
  assign at_final = at_last && (pass_q == fc_ctrl_pkg::LAST_PASS);

  always_comb begin
    step.valid = run_en;
    step.first = (index_q == '0);
    step.last  = at_last;
    step.pass  = pass_q;
    step.index = index_q;
  end

  assign done_steps = run_en && at_final;  // pass 4, index 99

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      index_q <= '0;
      pass_q  <= '0;
    end else if (run_en) begin
      index_q <= at_last ? '0 : index_q + 1'b1;
      if (at_final) begin
        pass_q <= '0;
      end else if (at_last) begin
        pass_q <= pass_q + 1'b1;
      end
    end
  end

  a_pass_in_range : assert property (@(posedge clk) disable iff (!rst_n)
    pass_q <= fc_ctrl_pkg::LAST_PASS)
    else $error("pass counter out of range");

endmodule

`default_nettype wire

// ==== hdl/fc_layer_fsm.sv ====
/*
 * layer controller
 * starts a vector once its bank is full, runs the passes, waits for the
 * last result to leave and then hands the bank back to the buffer
 */
`timescale 1ns/1ps
`default_nettype none

module fc_layer_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic vector_ready,
  input  logic done_steps,
  input  logic vector_done,
  output logic run_en,
  output logic bank_release,
  output logic busy
);

  fc_ctrl_pkg::fsm_state_t state;
  fc_ctrl_pkg::fsm_state_t state_next;

  always_comb begin
    state_next = state;
    unique case (state)
      fc_ctrl_pkg::IDLE: begin
        if (vector_ready) begin
          state_next = fc_ctrl_pkg::RUN;
        end
      end
      fc_ctrl_pkg::RUN: begin
        if (done_steps) begin
          state_next = fc_ctrl_pkg::FLUSH;
        end
      end
      fc_ctrl_pkg::FLUSH: begin
        if (vector_done) begin
          state_next = fc_ctrl_pkg::IDLE;
        end
      end
      default: state_next = fc_ctrl_pkg::IDLE;
    endcase
  end

  assign run_en       = (state == fc_ctrl_pkg::RUN);
  assign bank_release = (state == fc_ctrl_pkg::FLUSH) && vector_done;  // last result out

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= fc_ctrl_pkg::IDLE;
      busy  <= 1'b0;
    end else begin
      state <= state_next;
      // held one extra cycle so a queued vector keeps busy high
      busy  <= (state_next != fc_ctrl_pkg::IDLE) || bank_release;
    end
  end

  a_done_in_run : assert property (@(posedge clk) disable iff (!rst_n)
    done_steps |-> state == fc_ctrl_pkg::RUN)
    else $error("step counter finished outside RUN");

endmodule

`default_nettype wire

// ==== hdl/fc_result_serializer.sv ====
/*
 * result serializer
 * turns the per-pass lane result pair into a stream of indexed outputs,
 * lane 0 first and lane 1 on the next cycle
 */
`timescale 1ns/1ps
`default_nettype none

module fc_result_serializer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  fc_ctrl_pkg::fc_lane_result_t lane_result,
  output logic                         out_valid,
  output fc_ctrl_pkg::out_idx_t        out_index,
  output fc_fmt_pkg::sample_t          out_data,
  output logic                         out_last,
  output logic                         vector_done
);

  logic                hold_valid;
  fc_ctrl_pkg::pass_t  hold_pass;
  fc_fmt_pkg::sample_t hold_data;  // lane 1 waits here one cycle

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      out_last   <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      hold_valid <= lane_result.valid;
      out_valid  <= lane_result.valid || hold_valid;
      out_last   <= !lane_result.valid && hold_valid &&
                    (hold_pass == fc_ctrl_pkg::LAST_PASS);
    end
  end

  always_ff @(posedge clk) begin
    if (lane_result.valid) begin
      hold_pass <= lane_result.pass;
      hold_data <= lane_result.data[1];
      out_data  <= lane_result.data[0];
      out_index <= fc_ctrl_pkg::out_idx_t'(int'(lane_result.pass) * fc_ctrl_pkg::N_LANES);
    end else if (hold_valid) begin
      out_data  <= hold_data;
      out_index <= fc_ctrl_pkg::out_idx_t'(int'(hold_pass) * fc_ctrl_pkg::N_LANES + 1);
    end
  end

  assign vector_done = out_last;  // index 9 is the end of the vector

endmodule

`default_nettype wire

// ==== hdl/fc_layer_top.sv ====
/*
 * fully connected layer engine, 100 inputs to 10 outputs in Q6.10
 * two MAC lanes share each pass over a double-buffered input vector
 */
`timescale 1ns/1ps
`default_nettype none

module fc_layer_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  fc_fmt_pkg::sample_t   in_sample,
  output logic                  out_valid,
  output fc_ctrl_pkg::out_idx_t out_index,
  output fc_fmt_pkg::sample_t   out_data,
  output logic                  out_last,
  output logic                  busy
);

  logic                         vector_ready;
  logic                         bank_release;
  logic                         run_en;
  logic                         done_steps;
  logic                         vector_done;
  fc_ctrl_pkg::fc_step_t        step;
  fc_ctrl_pkg::fc_step_t        step_d;       // aligned with read data
  fc_fmt_pkg::sample_t          rd_sample;
  fc_ctrl_pkg::lane_data_t      weights;
  fc_ctrl_pkg::lane_data_t      lane_out;
  logic [fc_ctrl_pkg::N_LANES-1:0] lane_valid;
  fc_ctrl_pkg::pass_t           result_pass;
  fc_ctrl_pkg::fc_lane_result_t lane_result;

  fc_vector_buffer i_buffer (
    .clk, .rst_n, .in_valid, .in_sample,
    .rd_index(step.index), .rd_sample,
    .vector_ready, .bank_release
  );

  fc_step_counter i_counter (.clk, .rst_n, .run_en, .step, .done_steps);

  fc_layer_fsm i_fsm (
    .clk, .rst_n, .vector_ready, .done_steps, .vector_done,
    .run_en, .bank_release, .busy
  );

  fc_weight_rom i_rom (.clk, .pass(step.pass), .index(step.index), .weights);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_d <= '0;
    end else begin
      step_d <= step;
    end
  end

  always_ff @(posedge clk) begin
    if (step_d.valid && step_d.last) begin
      result_pass <= step_d.pass;  // lanes finish this pass next cycle
    end
  end

  for (genvar l = 0; l < fc_ctrl_pkg::N_LANES; l++) begin : g_lane
    fc_mac_lane i_lane (
      .clk, .rst_n, .step(step_d), .sample(rd_sample), .weight(weights[l]),
      .result(lane_out[l]), .result_valid(lane_valid[l])
    );
  end

  assign lane_result = '{valid: &lane_valid, pass: result_pass, data: lane_out};

  fc_result_serializer i_serializer (
    .clk, .rst_n, .lane_result,
    .out_valid, .out_index, .out_data, .out_last, .vector_done
  );

endmodule

`default_nettype wire

// ==== verif/fc_layer_tb.sv ====
/*
 * testbench for the fully connected layer engine
 * drives input vectors, models the expected outputs from the weight rule
 * and checks the result stream and busy with assertions
 */
`timescale 1ns/1ps
`default_nettype none

module fc_layer_tb;

  localparam int VECTOR_CYCLES  = 700;  // send plus five passes plus flush, rounded up
  localparam int N_VECTORS      = 6;
  localparam int TIMEOUT_CYCLES = N_VECTORS * VECTOR_CYCLES + 1500;

  localparam fc_ctrl_pkg::out_idx_t LAST_OUT = fc_ctrl_pkg::out_idx_t'(fc_ctrl_pkg::N_OUTPUTS - 1);

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  fc_fmt_pkg::sample_t   in_sample;
  logic                  out_valid;
  fc_ctrl_pkg::out_idx_t out_index;
  fc_fmt_pkg::sample_t   out_data;
  logic                  out_last;
  logic                  busy;

  fc_fmt_pkg::sample_t   vec [fc_ctrl_pkg::N_INPUTS];  // vector being prepared
  fc_fmt_pkg::sample_t   exp_q [$];                    // expected results, in order
  fc_ctrl_pkg::out_idx_t exp_index;
  int                    vectors_sent;
  int                    vectors_done;
  int                    cycle_count;
  logic                  pending;

  assign pending = (vectors_sent != vectors_done);

  fc_layer_top i_dut (
    .clk, .rst_n, .in_valid, .in_sample,
    .out_valid, .out_index, .out_data, .out_last, .busy
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fill_random(input int range);
    for (int i = 0; i < fc_ctrl_pkg::N_INPUTS; i++) begin
      vec[i] = fc_fmt_pkg::sample_t'(int'($urandom_range(0, 2 * range - 1)) - range);
    end
  endtask

  task automatic fill_const(input fc_fmt_pkg::sample_t value);
    for (int i = 0; i < fc_ctrl_pkg::N_INPUTS; i++) begin
      vec[i] = value;
    end
  endtask

  // full scale samples signed like the row 0 weights, far past the Q6.10 range
  task automatic fill_saturating();
    for (int i = 0; i < fc_ctrl_pkg::N_INPUTS; i++) begin
      vec[i] = (fc_fmt_pkg::weight_of(0, i) < 0) ? fc_fmt_pkg::SAMPLE_MIN
                                                 : fc_fmt_pkg::SAMPLE_MAX;
    end
  endtask

  // dot product per output row, floor scaling and clamp to Q6.10
  task automatic push_expected();
    longint acc;
    longint scaled;
    for (int o = 0; o < fc_ctrl_pkg::N_OUTPUTS; o++) begin
      acc = 0;
      for (int i = 0; i < fc_ctrl_pkg::N_INPUTS; i++) begin
        acc += longint'(vec[i]) * longint'(fc_fmt_pkg::weight_of(o, i));
      end
      scaled = acc >>> fc_fmt_pkg::FRAC_BITS;
      if (scaled > longint'(fc_fmt_pkg::SAMPLE_MAX)) begin
        exp_q.push_back(fc_fmt_pkg::SAMPLE_MAX);
      end else if (scaled < longint'(fc_fmt_pkg::SAMPLE_MIN)) begin
        exp_q.push_back(fc_fmt_pkg::SAMPLE_MIN);
      end else begin
        exp_q.push_back(fc_fmt_pkg::sample_t'(scaled));
      end
    end
  endtask

  task automatic send_vector();
    for (int i = 0; i < fc_ctrl_pkg::N_INPUTS; i++) begin
      @(negedge clk);
      in_valid  = 1'b1;
      in_sample = vec[i];
      if ($urandom_range(0, 7) == 0) begin  // occasional idle cycle
        @(negedge clk);
        in_valid = 1'b0;
      end
    end
    push_expected();
    vectors_sent++;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (pending || busy) begin
      @(negedge clk);
    end
  endtask

  initial begin
    int seed_ack;
    seed_ack     = $urandom(41);
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_sample    = '0;
    exp_index    = '0;
    vectors_sent = 0;
    vectors_done = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (10) @(negedge clk);  // outputs must stay quiet here

    fill_random(2048);  // within +-2.0
    send_vector();
    wait_idle();

    fill_const(fc_fmt_pkg::SAMPLE_MAX);
    send_vector();
    wait_idle();
    fill_const(fc_fmt_pkg::SAMPLE_MIN);
    send_vector();
    wait_idle();
    fill_saturating();
    send_vector();
    wait_idle();

    // second vector lands while the first is computed
    fill_random(4096);
    send_vector();
    fill_random(1024);
    send_vector();
    wait_idle();

    repeat (3) @(negedge clk);
    $display("Test completed successfully");
    $finish;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout after %0d cycles, results still missing", cycle_count));
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    fc_fmt_pkg::sample_t exp_data;
    if (rst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        fail_run("output strobe with no vector outstanding");
      end else begin
        exp_data = exp_q.pop_front();
        a_index : assert (out_index == exp_index)
          else fail_run($sformatf("mismatch out_index: got 0x%h expected 0x%h",
                                  out_index, exp_index));
        a_data : assert (out_data == exp_data)
          else fail_run($sformatf("mismatch out_data: got 0x%h expected 0x%h",
                                  out_data, exp_data));
        a_last_flag : assert (out_last == (exp_index == LAST_OUT))
          else fail_run($sformatf("mismatch out_last: got 0x%h expected 0x%h",
                                  out_last, exp_index == LAST_OUT));
        if (exp_index == LAST_OUT) begin
          exp_index = '0;
          vectors_done++;
        end else begin
          exp_index = exp_index + 1'b1;
        end
      end
    end
  end

  a_quiet_until_first : assert property (@(posedge clk) disable iff (!rst_n)
    (vectors_sent == 0) |-> !busy && !out_valid && !out_last)
    else fail_run("busy or output active before a full vector was written");

  a_last_on_index : assert property (@(posedge clk) disable iff (!rst_n)
    out_last |-> out_valid && (out_index == LAST_OUT))
    else fail_run($sformatf("mismatch out_index: got 0x%h expected 0x%h on out_last",
                            out_index, LAST_OUT));

  a_busy_with_output : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> busy)
    else fail_run("busy low while results are coming out");

  a_busy_while_pending : assert property (@(posedge clk) disable iff (!rst_n)
    $past(pending, 2) && pending |-> busy)
    else fail_run("busy low while a full vector is waiting");

  a_busy_after_last : assert property (@(posedge clk) disable iff (!rst_n)
    $past(out_last) |-> busy)
    else fail_run("busy dropped on the cycle after out_last");

  // vectors_done already counts the vector whose out_last was seen
  a_busy_kept : assert property (@(posedge clk) disable iff (!rst_n)
    $past(out_last, 2) && $past(pending, 2) |-> busy)
    else fail_run("busy dropped between two queued vectors");

  a_busy_falls : assert property (@(posedge clk) disable iff (!rst_n)
    $past(out_last, 2) && !$past(pending, 2) |-> !busy)
    else fail_run("busy still high with no vector waiting");

endmodule

`default_nettype wire

// ==== files.f ====
hdl/fc_fmt_pkg.sv
hdl/fc_ctrl_pkg.sv
hdl/fc_vector_buffer.sv
hdl/fc_weight_rom.sv
hdl/fc_mac_lane.sv
hdl/fc_step_counter.sv
hdl/fc_layer_fsm.sv
hdl/fc_result_serializer.sv
hdl/fc_layer_top.sv
verif/fc_layer_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the fully connected layer testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fc_layer_tb \
  -f files.f -o fc_layer_sim \
  && ./obj_dir/fc_layer_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
